// File: src/ahb_pkg.sv
package ahb_pkg;

    localparam int HADDR_WIDTH = 32;
    localparam int HDATA_WIDTH = 32;

    // AHB-Lite transfer type
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // Transfer size, words at most
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_t;

    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_t;

    // Top address nibble of each region
    localparam logic [3:0] REGION_ITCM = 4'h0;
    localparam logic [3:0] REGION_DTCM = 4'h2;
    localparam logic [3:0] REGION_APB  = 4'h4;

    // Byte lanes touched by a transfer of the given size and offset
    function automatic logic [HDATA_WIDTH/8-1:0] byte_strb(hsize_t size, logic [1:0] addr);
        logic [HDATA_WIDTH/8-1:0] strb;
        case (size)
            BYTE:    strb = {{(HDATA_WIDTH/8-1){1'b0}}, 1'b1} << addr;
            HALF:    strb = {{(HDATA_WIDTH/8-2){1'b0}}, 2'b11} << {addr[1], 1'b0};
            default: strb = '1;
        endcase
        return strb;
    endfunction

endpackage

// File: src/apb_pkg.sv
package apb_pkg;

    // Low half of haddr is passed to the APB side
    localparam int PADDR_WIDTH = 16;

    // Bridge sequencer
    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        WAIT_EN = 2'b01,
        SETUP   = 2'b10,
        ACCESS  = 2'b11
    } apb_state_t;

endpackage

// File: src/ahb_interconnect.sv
module ahb_interconnect (
    input  logic                                 hclk,
    input  logic                                 hresetn,
    input  logic [ahb_pkg::HADDR_WIDTH-1:0]      haddr_i,
    input  ahb_pkg::htrans_t                     htrans_i,
    input  logic                                 hready_i,
    output logic [2:0]                           hsel_o,
    input  logic [2:0]                           hreadyout_i,
    input  ahb_pkg::hresp_t [2:0]                hresp_i,
    input  logic [2:0][ahb_pkg::HDATA_WIDTH-1:0] hrdata_i,
    output logic                                 hready_o,
    output ahb_pkg::hresp_t                      hresp_o,
    output logic [ahb_pkg::HDATA_WIDTH-1:0]      hrdata_o
);

    logic [3:0]      region;
    logic            trans_valid;
    logic            unmapped;
    logic [2:0]      dp_sel_q;
    logic            def_ready_q;
    ahb_pkg::hresp_t def_resp_q;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    assign region    = haddr_i[ahb_pkg::HADDR_WIDTH-1 -: 4];
    assign hsel_o[0] = (region == ahb_pkg::REGION_ITCM);
    assign hsel_o[1] = (region == ahb_pkg::REGION_DTCM);
    assign hsel_o[2] = (region == ahb_pkg::REGION_APB);

    assign trans_valid = (htrans_i == ahb_pkg::NONSEQ) || (htrans_i == ahb_pkg::SEQ);
    assign unmapped    = hready_i && trans_valid && (hsel_o == 3'b000);

    // Owner of the data phase, all zero means default slave
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            dp_sel_q <= 3'b000;
        end else if (hready_i) begin
            dp_sel_q <= hsel_o;
        end
    end

    // ----------------------------------------
    // Default slave, two-cycle ERROR
    // ----------------------------------------
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            def_ready_q <= 1'b1;
            def_resp_q  <= ahb_pkg::OKAY;
        end else if (!def_ready_q) begin
            // Second cycle of the error response
            def_ready_q <= 1'b1;
            def_resp_q  <= ahb_pkg::ERROR;
        end else if (unmapped) begin
            def_ready_q <= 1'b0;
            def_resp_q  <= ahb_pkg::ERROR;
        end else begin
            def_ready_q <= 1'b1;
            def_resp_q  <= ahb_pkg::OKAY;
        end
    end

    // Response mux
    always_comb begin
        hready_o = def_ready_q;
        hresp_o  = def_resp_q;
        hrdata_o = '0;
        for (int i = 0; i < 3; i++) begin
            if (dp_sel_q[i]) begin
                hready_o = hreadyout_i[i];
                hresp_o  = hresp_i[i];
                hrdata_o = hrdata_i[i];
            end
        end
    end

endmodule

// File: src/ahb_sram.sv
module ahb_sram #(
    parameter int DEPTH = 64
) (
    input  logic                            hclk,
    input  logic                            hresetn,
    input  logic                            hsel_i,
    input  logic [ahb_pkg::HADDR_WIDTH-1:0] haddr_i,
    input  ahb_pkg::htrans_t                htrans_i,
    input  logic                            hwrite_i,
    input  ahb_pkg::hsize_t                 hsize_i,
    input  logic [ahb_pkg::HDATA_WIDTH-1:0] hwdata_i,
    input  logic                            hready_i,
    output logic [ahb_pkg::HDATA_WIDTH-1:0] hrdata_o,
    output logic                            hreadyout_o,
    output ahb_pkg::hresp_t                 hresp_o
);

    localparam int AW = $clog2(DEPTH);
    localparam int NB = ahb_pkg::HDATA_WIDTH / 8;

    logic [ahb_pkg::HDATA_WIDTH-1:0] mem [DEPTH];

    logic            trans_valid;
    logic            wr_q;
    logic [AW-1:0]   widx_q;
    logic [1:0]      boff_q;
    ahb_pkg::hsize_t size_q;
    logic [NB-1:0]   strb;

    assign trans_valid = hsel_i && hready_i &&
                         ((htrans_i == ahb_pkg::NONSEQ) || (htrans_i == ahb_pkg::SEQ));

    // Address phase controls
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            wr_q <= 1'b0;
        end else if (hready_i) begin
            wr_q <= trans_valid && hwrite_i;
        end
    end

    always_ff @(posedge hclk) begin
        if (trans_valid) begin
            widx_q <= haddr_i[AW+1:2];
            boff_q <= haddr_i[1:0];
            size_q <= hsize_i;
        end
    end

    assign strb = ahb_pkg::byte_strb(size_q, boff_q);

    // Write lands at the end of the data phase
    always_ff @(posedge hclk) begin
        if (wr_q && hready_i) begin
            for (int i = 0; i < NB; i++) begin
                if (strb[i]) begin
                    mem[widx_q][8*i +: 8] <= hwdata_i[8*i +: 8];
                end
            end
        end
    end

    // Zero wait states, read straight from the array
    assign hrdata_o    = mem[widx_q];
    assign hreadyout_o = 1'b1;
    assign hresp_o     = ahb_pkg::OKAY;

endmodule

// File: src/apb_clk_enable.sv
module apb_clk_enable #(
    parameter int DIV_WID = 4
) (
    input  logic               hclk,
    input  logic               hresetn,
    input  logic [DIV_WID-1:0] div_factor_i,
    output logic               pclken_o,
    output logic               presetn_o
);

    logic [DIV_WID-1:0] cnt_q;
    logic [1:0]         rst_sync_q;

    // Down-counter, one enable every div_factor_i+1 cycles
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            cnt_q <= '0;
        end else if (cnt_q == '0) begin
            cnt_q <= div_factor_i;
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign pclken_o = (cnt_q == '0);

    // Async assert, sync release
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            rst_sync_q <= 2'b00;
        end else begin
            rst_sync_q <= {rst_sync_q[0], 1'b1};
        end
    end

    assign presetn_o = rst_sync_q[1];

endmodule

// File: src/ahb2apb_bridge.sv
module ahb2apb_bridge (
    input  logic                              hclk,
    input  logic                              hresetn,
    input  logic                              hsel_i,
    input  logic [ahb_pkg::HADDR_WIDTH-1:0]   haddr_i,
    input  ahb_pkg::htrans_t                  htrans_i,
    input  logic                              hwrite_i,
    input  ahb_pkg::hsize_t                   hsize_i,
    input  logic [ahb_pkg::HDATA_WIDTH-1:0]   hwdata_i,
    input  logic                              hready_i,
    input  logic                              pclken_i,
    output logic                              hreadyout_o,
    output ahb_pkg::hresp_t                   hresp_o,
    output logic [ahb_pkg::HDATA_WIDTH-1:0]   hrdata_o,
    output logic [apb_pkg::PADDR_WIDTH-1:0]   paddr_o,
    output logic                              psel_o,
    output logic                              penable_o,
    output logic                              pwrite_o,
    output logic [ahb_pkg::HDATA_WIDTH-1:0]   pwdata_o,
    output logic [ahb_pkg::HDATA_WIDTH/8-1:0] pstrb_o,
    input  logic                              pready_i,
    input  logic [ahb_pkg::HDATA_WIDTH-1:0]   prdata_i
);

    apb_pkg::apb_state_t             state_q;
    logic                            start;
    logic                            apb_done;
    logic [apb_pkg::PADDR_WIDTH-1:0] addr_q;
    logic                            write_q;
    ahb_pkg::hsize_t                 size_q;
    logic [ahb_pkg::HDATA_WIDTH-1:0] wdata_q;
    logic [ahb_pkg::HDATA_WIDTH-1:0] rdata_q;

    assign start = hsel_i && hready_i &&
                   ((htrans_i == ahb_pkg::NONSEQ) || (htrans_i == ahb_pkg::SEQ));

    assign apb_done = (state_q == apb_pkg::ACCESS) && pclken_i && pready_i;

    // ----------------------------------------
    // Sequencer
    // ----------------------------------------
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            state_q <= apb_pkg::IDLE;
        end else begin
            case (state_q)
                apb_pkg::IDLE: begin
                    if (start) begin
                        state_q <= apb_pkg::WAIT_EN;
                    end
                end
                apb_pkg::WAIT_EN: begin
                    // Align SETUP to an APB clock edge
                    if (pclken_i) begin
                        state_q <= apb_pkg::SETUP;
                    end
                end
                apb_pkg::SETUP: begin
                    if (pclken_i) begin
                        state_q <= apb_pkg::ACCESS;
                    end
                end
                apb_pkg::ACCESS: begin
                    if (apb_done) begin
                        state_q <= apb_pkg::IDLE;
                    end
                end
                default: state_q <= apb_pkg::IDLE;
            endcase
        end
    end

    // Transfer payload
    always_ff @(posedge hclk) begin
        if ((state_q == apb_pkg::IDLE) && start) begin
            addr_q  <= haddr_i[apb_pkg::PADDR_WIDTH-1:0];
            write_q <= hwrite_i;
            size_q  <= hsize_i;
        end
        // hwdata is valid once the data phase has begun
        if ((state_q == apb_pkg::WAIT_EN) && pclken_i) begin
            wdata_q <= hwdata_i;
        end
        if (apb_done) begin
            rdata_q <= prdata_i;
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    assign hreadyout_o = (state_q == apb_pkg::IDLE);
    assign hresp_o     = ahb_pkg::OKAY;
    assign hrdata_o    = rdata_q;

    assign paddr_o   = addr_q;
    assign psel_o    = (state_q == apb_pkg::SETUP) || (state_q == apb_pkg::ACCESS);
    assign penable_o = (state_q == apb_pkg::ACCESS);
    assign pwrite_o  = write_q;
    assign pwdata_o  = wdata_q;
    // No strobes on reads
    assign pstrb_o   = write_q ? ahb_pkg::byte_strb(size_q, addr_q[1:0]) : '0;

endmodule

// File: src/apb_sram.sv
module apb_sram #(
    parameter int DEPTH = 64
) (
    input  logic                              hclk,
    input  logic                              presetn_i,
    input  logic                              pclken_i,
    input  logic [apb_pkg::PADDR_WIDTH-1:0]   paddr_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [ahb_pkg::HDATA_WIDTH-1:0]   pwdata_i,
    input  logic [ahb_pkg::HDATA_WIDTH/8-1:0] pstrb_i,
    output logic                              pready_o,
    output logic [ahb_pkg::HDATA_WIDTH-1:0]   prdata_o
);

    localparam int AW = $clog2(DEPTH);
    localparam int NB = ahb_pkg::HDATA_WIDTH / 8;

    logic [ahb_pkg::HDATA_WIDTH-1:0] mem [DEPTH];

    logic [AW-1:0] widx;
    logic          wr_en;

    assign widx = paddr_i[AW+1:2];

    // ACCESS phase on an APB clock edge, held off while in reset
    assign wr_en = presetn_i && pclken_i && psel_i && penable_i && pwrite_i;

    always_ff @(posedge hclk) begin
        if (wr_en) begin
            for (int i = 0; i < NB; i++) begin
                if (pstrb_i[i]) begin
                    mem[widx][8*i +: 8] <= pwdata_i[8*i +: 8];
                end
            end
        end
    end

    assign prdata_o = mem[widx];
    assign pready_o = 1'b1;

endmodule

// File: src/soc_top.sv
module soc_top #(
    parameter int ITCM_DEPTH    = 64,
    parameter int DTCM_DEPTH    = 64,
    parameter int APB_MEM_DEPTH = 64,
    parameter int DIV_WID       = 4
) (
    input  logic                            hclk,
    input  logic                            hresetn,
    input  logic [DIV_WID-1:0]              div_factor_i,
    input  logic [ahb_pkg::HADDR_WIDTH-1:0] haddr_i,
    input  ahb_pkg::htrans_t                htrans_i,
    input  logic                            hwrite_i,
    input  ahb_pkg::hsize_t                 hsize_i,
    input  logic [ahb_pkg::HDATA_WIDTH-1:0] hwdata_i,
    output logic [ahb_pkg::HDATA_WIDTH-1:0] hrdata_o,
    output logic                            hready_o,
    output ahb_pkg::hresp_t                 hresp_o
);

    // Slave index: 0 ITCM, 1 DTCM, 2 APB bridge
    logic [2:0]                           hsel;
    logic [2:0]                           hreadyout;
    ahb_pkg::hresp_t [2:0]                hresp;
    logic [2:0][ahb_pkg::HDATA_WIDTH-1:0] hrdata;

    logic                              pclken;
    logic                              presetn;
    logic [apb_pkg::PADDR_WIDTH-1:0]   paddr;
    logic                              psel;
    logic                              penable;
    logic                              pwrite;
    logic [ahb_pkg::HDATA_WIDTH-1:0]   pwdata;
    logic [ahb_pkg::HDATA_WIDTH/8-1:0] pstrb;
    logic                              pready;
    logic [ahb_pkg::HDATA_WIDTH-1:0]   prdata;

    // ----------------------------------------
    // AHB side
    // ----------------------------------------
    ahb_interconnect u_interconnect (
        .hclk        (hclk),
        .hresetn     (hresetn),
        .haddr_i     (haddr_i),
        .htrans_i    (htrans_i),
        .hready_i    (hready_o),
        .hsel_o      (hsel),
        .hreadyout_i (hreadyout),
        .hresp_i     (hresp),
        .hrdata_i    (hrdata),
        .hready_o    (hready_o),
        .hresp_o     (hresp_o),
        .hrdata_o    (hrdata_o)
    );

    ahb_sram #(.DEPTH(ITCM_DEPTH)) u_itcm (
        .hclk        (hclk),
        .hresetn     (hresetn),
        .hsel_i      (hsel[0]),
        .haddr_i     (haddr_i),
        .htrans_i    (htrans_i),
        .hwrite_i    (hwrite_i),
        .hsize_i     (hsize_i),
        .hwdata_i    (hwdata_i),
        .hready_i    (hready_o),
        .hrdata_o    (hrdata[0]),
        .hreadyout_o (hreadyout[0]),
        .hresp_o     (hresp[0])
    );

    ahb_sram #(.DEPTH(DTCM_DEPTH)) u_dtcm (
        .hclk        (hclk),
        .hresetn     (hresetn),
        .hsel_i      (hsel[1]),
        .haddr_i     (haddr_i),
        .htrans_i    (htrans_i),
        .hwrite_i    (hwrite_i),
        .hsize_i     (hsize_i),
        .hwdata_i    (hwdata_i),
        .hready_i    (hready_o),
        .hrdata_o    (hrdata[1]),
        .hreadyout_o (hreadyout[1]),
        .hresp_o     (hresp[1])
    );

    // ----------------------------------------
    // APB side
    // ----------------------------------------
    apb_clk_enable #(.DIV_WID(DIV_WID)) u_clk_enable (
        .hclk         (hclk),
        .hresetn      (hresetn),
        .div_factor_i (div_factor_i),
        .pclken_o     (pclken),
        .presetn_o    (presetn)
    );

    ahb2apb_bridge u_bridge (
        .hclk        (hclk),
        .hresetn     (hresetn),
        .hsel_i      (hsel[2]),
        .haddr_i     (haddr_i),
        .htrans_i    (htrans_i),
        .hwrite_i    (hwrite_i),
        .hsize_i     (hsize_i),
        .hwdata_i    (hwdata_i),
        .hready_i    (hready_o),
        .pclken_i    (pclken),
        .hreadyout_o (hreadyout[2]),
        .hresp_o     (hresp[2]),
        .hrdata_o    (hrdata[2]),
        .paddr_o     (paddr),
        .psel_o      (psel),
        .penable_o   (penable),
        .pwrite_o    (pwrite),
        .pwdata_o    (pwdata),
        .pstrb_o     (pstrb),
        .pready_i    (pready),
        .prdata_i    (prdata)
    );

    apb_sram #(.DEPTH(APB_MEM_DEPTH)) u_apb_mem (
        .hclk      (hclk),
        .presetn_i (presetn),
        .pclken_i  (pclken),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .pstrb_i   (pstrb),
        .pready_o  (pready),
        .prdata_o  (prdata)
    );

endmodule

// File: dv/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic hclk,
    output logic hresetn
);

    initial begin
        hclk = 1'b0;
        forever #(PERIOD / 2) hclk = ~hclk;
    end

    // Reset held low for the first few cycles
    initial begin
        hresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge hclk);
        hresetn <= 1'b1;
    end

endmodule

// File: dv/soc_tb.sv
module soc_tb;

    localparam int DIV_WID        = 4;
    localparam int HREADY_TIMEOUT = 200;
    localparam int RESET_TIMEOUT  = 50;

    typedef struct packed {
        logic [ahb_pkg::HADDR_WIDTH-1:0] addr;
        logic                            write;
        ahb_pkg::hsize_t                 size;
        logic [ahb_pkg::HDATA_WIDTH-1:0] data;
        logic [ahb_pkg::HDATA_WIDTH-1:0] exp_data;
        ahb_pkg::hresp_t                 exp_resp;
        logic [DIV_WID-1:0]              div;
    } entry_t;

    logic                            hclk;
    logic                            hresetn;
    logic [DIV_WID-1:0]              div_factor_i;
    logic [ahb_pkg::HADDR_WIDTH-1:0] haddr_i;
    ahb_pkg::htrans_t                htrans_i;
    logic                            hwrite_i;
    ahb_pkg::hsize_t                 hsize_i;
    logic [ahb_pkg::HDATA_WIDTH-1:0] hwdata_i;
    logic [ahb_pkg::HDATA_WIDTH-1:0] hrdata_o;
    logic                            hready_o;
    ahb_pkg::hresp_t                 hresp_o;

    entry_t     stim_q[$];
    // Byte model per mapped region: 0 ITCM, 1 DTCM, 2 APB memory
    logic [7:0] model_mem [3][256];
    int         errors;
    int         tests_run;
    int         tests_failed;
    logic       timed_out;

    tb_clk_gen u_clk_gen (
        .hclk    (hclk),
        .hresetn (hresetn)
    );

    soc_top #(.DIV_WID(DIV_WID)) DUT (
        .hclk         (hclk),
        .hresetn      (hresetn),
        .div_factor_i (div_factor_i),
        .haddr_i      (haddr_i),
        .htrans_i     (htrans_i),
        .hwrite_i     (hwrite_i),
        .hsize_i      (hsize_i),
        .hwdata_i     (hwdata_i),
        .hrdata_o     (hrdata_o),
        .hready_o     (hready_o),
        .hresp_o      (hresp_o)
    );

    // ----------------------------------------
    // Memory map and byte model
    // ----------------------------------------
    // 3 means no region answers the address
    function automatic logic [1:0] region_index(logic [31:0] addr);
        case (addr[31:28])
            4'h0:    return 2'd0;
            4'h2:    return 2'd1;
            4'h4:    return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    function automatic void model_write(logic [31:0] addr, ahb_pkg::hsize_t size,
                                        logic [31:0] data);
        logic [3:0] lanes;
        logic [1:0] r;
        r = region_index(addr);
        case (size)
            ahb_pkg::BYTE: lanes = 4'b0001 << addr[1:0];
            ahb_pkg::HALF: lanes = addr[1] ? 4'b1100 : 4'b0011;
            default:       lanes = 4'b1111;
        endcase
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                model_mem[r][{addr[7:2], 2'(i)}] = data[8*i +: 8];
            end
        end
    endfunction

    function automatic logic [31:0] model_word(logic [31:0] addr);
        logic [1:0] r;
        r = region_index(addr);
        return {model_mem[r][{addr[7:2], 2'd3}], model_mem[r][{addr[7:2], 2'd2}],
                model_mem[r][{addr[7:2], 2'd1}], model_mem[r][{addr[7:2], 2'd0}]};
    endfunction

    // Expected values follow the model as the table is built
    function automatic void add_entry(logic [31:0] addr, logic write,
                                      ahb_pkg::hsize_t size, logic [DIV_WID-1:0] div);
        entry_t e;
        e.addr     = addr;
        e.write    = write;
        e.size     = size;
        e.div      = div;
        e.data     = $urandom();
        e.exp_data = '0;
        e.exp_resp = ahb_pkg::OKAY;
        if (region_index(addr) == 2'd3) begin
            e.exp_resp = ahb_pkg::ERROR;
        end else if (write) begin
            model_write(addr, size, e.data);
        end else begin
            e.exp_data = model_word(addr);
        end
        stim_q.push_back(e);
    endfunction

    function automatic void build_table();
        logic [DIV_WID-1:0] divs [3];
        divs = '{4'd0, 4'd3, 4'd15};
        // Same offset in both TCMs
        add_entry(32'h0000_0010, 1'b1, ahb_pkg::WORD, 4'd0);
        add_entry(32'h2000_0010, 1'b1, ahb_pkg::WORD, 4'd0);
        add_entry(32'h0000_0010, 1'b0, ahb_pkg::WORD, 4'd0);
        add_entry(32'h2000_0010, 1'b0, ahb_pkg::WORD, 4'd0);
        // Byte and halfword merge
        add_entry(32'h2000_0020, 1'b1, ahb_pkg::WORD, 4'd0);
        add_entry(32'h2000_0021, 1'b1, ahb_pkg::BYTE, 4'd0);
        add_entry(32'h2000_0022, 1'b1, ahb_pkg::HALF, 4'd0);
        add_entry(32'h2000_0020, 1'b0, ahb_pkg::WORD, 4'd0);
        add_entry(32'h0000_0013, 1'b1, ahb_pkg::BYTE, 4'd0);
        add_entry(32'h0000_0010, 1'b0, ahb_pkg::WORD, 4'd0);
        // APB region at three divide factors
        for (int k = 0; k < 3; k++) begin
            add_entry(32'h4000_0030 + 32'(4 * k), 1'b1, ahb_pkg::WORD, divs[k]);
            add_entry(32'h4000_0030 + 32'(4 * k), 1'b0, ahb_pkg::WORD, divs[k]);
        end
        add_entry(32'h4000_0032, 1'b1, ahb_pkg::HALF, 4'd3);
        add_entry(32'h4000_0030, 1'b0, ahb_pkg::WORD, 4'd3);
        // Unmapped
        add_entry(32'h8000_0000, 1'b0, ahb_pkg::WORD, 4'd0);
        add_entry(32'h8000_0004, 1'b1, ahb_pkg::WORD, 4'd0);
    endfunction

    // ----------------------------------------
    // Compare tasks and report
    // ----------------------------------------
    task automatic check_data(input string name, input logic [ahb_pkg::HDATA_WIDTH-1:0] got,
                              input logic [ahb_pkg::HDATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input ahb_pkg::hresp_t got,
                              input ahb_pkg::hresp_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %s, expected %s", $time, name, got.name(),
                     exp.name());
            errors++;
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_waits(input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t: hready_o low cycles = %0d, expected %0d", $time,
                     got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors > errs_before) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // ----------------------------------------
    // Bus driving
    // ----------------------------------------
    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (hresetn !== 1'b1) begin
            @(posedge hclk);
            cycles++;
            if (cycles >= RESET_TIMEOUT) begin
                $display("Timeout: reset was never released");
                timed_out = 1'b1;
                return;
            end
        end
    endtask

    // Sampled on the falling edge, first low cycle response kept
    task automatic wait_hready(output int waits, output ahb_pkg::hresp_t low_resp);
        waits    = 0;
        low_resp = ahb_pkg::OKAY;
        @(negedge hclk);
        while (!hready_o) begin
            if (waits == 0) begin
                low_resp = hresp_o;
            end
            waits++;
            if (waits >= HREADY_TIMEOUT) begin
                $display("Timeout: hready_o stayed low for %0d cycles", waits);
                timed_out = 1'b1;
                return;
            end
            @(negedge hclk);
        end
    endtask

    task automatic do_transfer(input entry_t e, output logic [31:0] rdata,
                               output ahb_pkg::hresp_t resp, output int waits,
                               output ahb_pkg::hresp_t low_resp);
        int              addr_waits;
        ahb_pkg::hresp_t addr_resp;
        rdata = '0;
        resp  = ahb_pkg::OKAY;
        @(posedge hclk);
        div_factor_i <= e.div;
        haddr_i      <= e.addr;
        htrans_i     <= ahb_pkg::NONSEQ;
        hwrite_i     <= e.write;
        hsize_i      <= e.size;
        wait_hready(addr_waits, addr_resp);
        if (timed_out) begin
            return;
        end
        // Data phase
        @(posedge hclk);
        htrans_i <= ahb_pkg::IDLE;
        hwdata_i <= e.data;
        wait_hready(waits, low_resp);
        rdata = hrdata_o;
        resp  = hresp_o;
    endtask

    // Read address phase overlaps the write data phase
    task automatic pipelined_write_read(input logic [31:0] addr, input logic [31:0] data,
                                        output logic [31:0] rdata,
                                        output ahb_pkg::hresp_t resp);
        int              waits;
        ahb_pkg::hresp_t low_resp;
        rdata = '0;
        resp  = ahb_pkg::OKAY;
        @(posedge hclk);
        haddr_i  <= addr;
        htrans_i <= ahb_pkg::NONSEQ;
        hwrite_i <= 1'b1;
        hsize_i  <= ahb_pkg::WORD;
        wait_hready(waits, low_resp);
        if (timed_out) begin
            return;
        end
        @(posedge hclk);
        hwrite_i <= 1'b0;
        hwdata_i <= data;
        wait_hready(waits, low_resp);
        if (timed_out) begin
            return;
        end
        @(posedge hclk);
        htrans_i <= ahb_pkg::IDLE;
        wait_hready(waits, low_resp);
        rdata = hrdata_o;
        resp  = hresp_o;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin : main
        entry_t          e;
        logic [31:0]     rdata;
        logic [31:0]     pipe_data;
        ahb_pkg::hresp_t resp;
        ahb_pkg::hresp_t low_resp;
        int              waits;
        int              errs_before;

        void'($urandom(32'h72ef6dc0));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        div_factor_i <= '0;
        haddr_i      <= '0;
        htrans_i     <= ahb_pkg::IDLE;
        hwrite_i     <= 1'b0;
        hsize_i      <= ahb_pkg::WORD;
        hwdata_i     <= '0;

        build_table();
        wait_reset_release();

        if (!timed_out) begin
            errs_before = errors;
            @(negedge hclk);
            check_ready("hready_o", hready_o, 1'b1);
            check_resp("hresp_o", hresp_o, ahb_pkg::OKAY);
            report_test("reset state", errs_before);
        end

        for (int i = 0; i < stim_q.size(); i++) begin
            if (timed_out) begin
                break;
            end
            e           = stim_q[i];
            errs_before = errors;
            do_transfer(e, rdata, resp, waits, low_resp);
            if (timed_out) begin
                break;
            end
            check_resp("hresp_o", resp, e.exp_resp);
            if (!e.write && e.exp_resp == ahb_pkg::OKAY) begin
                check_data("hrdata_o", rdata, e.exp_data);
            end
            case (region_index(e.addr))
                2'd2: begin
                    if (waits == 0) begin
                        $display("APB transfer at %h finished without wait states", e.addr);
                        errors++;
                    end
                end
                2'd3: begin
                    check_waits(waits, 1);
                    check_resp("hresp_o first cycle", low_resp, ahb_pkg::ERROR);
                end
                default: check_waits(waits, 0);
            endcase
            report_test($sformatf("%0d %s addr %h hsize %0d div %0d", i,
                                  e.write ? "write" : "read", e.addr, e.size, e.div),
                        errs_before);
        end

        if (!timed_out) begin
            errs_before = errors;
            pipe_data   = $urandom();
            model_write(32'h0000_0040, ahb_pkg::WORD, pipe_data);
            pipelined_write_read(32'h0000_0040, pipe_data, rdata, resp);
            if (!timed_out) begin
                check_resp("hresp_o", resp, ahb_pkg::OKAY);
                check_data("hrdata_o", rdata, model_word(32'h0000_0040));
                report_test("pipelined write then read", errs_before);
            end
        end

        $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
                 errors);
        if (!timed_out && errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: soc_top.f
src/ahb_pkg.sv
src/apb_pkg.sv
src/ahb_interconnect.sv
src/ahb_sram.sv
src/apb_clk_enable.sv
src/ahb2apb_bridge.sv
src/apb_sram.sv
src/soc_top.sv
dv/tb_clk_gen.sv
dv/soc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the soc_top testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --top-module soc_tb \
    --Mdir obj_dir -o soc_tb_sim \
    -f soc_top.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/soc_tb_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# Pass only when the testbench printed its pass line
if echo "$sim_out" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1
